//--- filelist.f
hw/videoPkg.sv
hw/pixStreamIf.sv
hw/hvsyncGen.sv
hw/patternGen.sv
hw/pixelFifo.sv
hw/videoOut.sv
hw/videoTop.sv
tb/tbVideoTop.sv

//--- Makefile
# Verilator build for the raster video source testbench

SIM      := verilator
FLAGS    := --binary --timing -j 0
TOP      := tbVideoTop
FILELIST := filelist.f
OBJDIR   := obj_dir
BIN      := $(OBJDIR)/V$(TOP)
PASS_MSG := *** TEST PASSED ***

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: compile
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q -F '$(PASS_MSG)'

clean:
	rm -rf $(OBJDIR)

//--- tb/tbVideoTop.sv
/*
 * testbench for the raster video source
 * small 13x7 raster, monitors for sync widths and periods,
 * display-enable counts and the colour pattern per pixel,
 * a table of measured against expected values at the end
 */
module tbVideoTop import videoPkg::*;
();

    // ------------------------------
    // DUT timing, small raster
    // ------------------------------
    localparam int lpHdisp  = 8;
    localparam int lpHback  = 2;
    localparam int lpHfront = 1;
    localparam int lpHsync  = 2;
    localparam int lpVdisp  = 4;
    localparam int lpVtop   = 1;
    localparam int lpVbot   = 1;
    localparam int lpVsync  = 1;
    localparam int lpDepth  = 16;
    localparam int lpHtotal = lpHdisp + lpHback + lpHfront + lpHsync;  // 13 clocks
    localparam int lpVtotal = lpVdisp + lpVtop + lpVbot + lpVsync;     // 7 lines
    localparam int lpFrames = 3;                // displayed frames checked
    localparam int lpFeWait = 2000;             // clocks allowed per oFe
    localparam int lpBig    = 32'h7fffffff;
    localparam pixelT lpBlank = '0;

    logic  iCLK, iRST;
    logic  oHsync, oVsync, oVde, oFe, oUnderflow;
    pixelT oRgb;

    // monitor state, -1 means no edge yet
    int hsPer = -1, hsPerMin = lpBig, hsPerMax = 0, hsW = 0, hsWMin = lpBig, hsWMax = 0;
    int vsW = 0, vsWMin = lpBig, vsWMax = 0;
    int fePer = -1, fePerMin = lpBig, fePerMax = 0, feW = 0, feWMax = 0, feCount = 0;
    int vdeFrame = 0, vdeLines = 0, vdeRun = 0, firstVde = -1;
    int frMin = lpBig, frMax = 0, linesMin = lpBig, linesMax = 0, runMin = lpBig, runMax = 0;
    int quietErrs = 0, pixErrs = 0, pixSeen = 0, passCount = 0, failCount = 0;
    bit underflowSeen = 0;
    logic prevHs = 0, prevVs = 0, prevVde = 0, prevFe = 0;
    string rowName[$];
    int    rowGot[$];
    int    rowExp[$];

    videoTop #(
        .pHdisplay(lpHdisp), .pHback(lpHback), .pHfront(lpHfront), .pHsync(lpHsync),
        .pVdisplay(lpVdisp), .pVtop(lpVtop), .pVbottom(lpVbot), .pVsync(lpVsync),
        .pFifoDepth(lpDepth)
    ) UUT (
        .iCLK(iCLK), .iRST(iRST), .oHsync(oHsync), .oVsync(oVsync), .oVde(oVde),
        .oFe(oFe), .oUnderflow(oUnderflow), .oRgb(oRgb)
    );

    initial
    begin
        iCLK = 1'b0;
        forever #10 iCLK = ~iCLK;               // period 20
    end

    // ------------------------------
    // compare and report
    // ------------------------------
    task automatic checkCount(input string sig, input int got, input int exp, output bit ok);
        ok = (got == exp);
        if (!ok)
            $display("ERROR %s: got 0x%0h, expected 0x%0h", sig, got, exp);
    endtask

    task automatic checkPix(input string sig, input pixelT got, input pixelT exp, output bit ok);
        ok = (got == exp);
        if (!ok)
            $display("ERROR %s: got 0x%04h, expected 0x%04h", sig, got, exp);
    endtask

    task automatic logResult(input string name, input bit ok);
        if (ok)
        begin
            $display("PASS  %s", name);
            passCount++;
        end
        else
        begin
            $display("FAIL  %s", name);
            failCount++;
        end
    endtask

    task automatic trackRange(inout int lo, inout int hi, input int val);
        if (val < lo)
            lo = val;
        if (val > hi)
            hi = val;
    endtask

    task automatic addRow(input string name, input int got, input int exp);
        rowName.push_back(name);
        rowGot.push_back(got);
        rowExp.push_back(exp);
    endtask

    // everything dark before the first frame end
    task automatic checkQuiet();
        bit a, b, c, d, e;
        checkCount("oHsync", int'(oHsync), 0, a);
        checkCount("oVsync", int'(oVsync), 0, b);
        checkCount("oVde", int'(oVde), 0, c);
        checkCount("oUnderflow", int'(oUnderflow), 0, d);
        checkPix("oRgb", oRgb, lpBlank, e);
        if (!(a && b && c && d && e))
            quietErrs++;
    endtask

    // red from x, green from y, blue from displayed frame count
    task automatic checkPixelAt();
        int    x, y, fr;
        pixelT expPix;
        bit    ok;
        x  = vdeFrame % lpHdisp;
        y  = vdeFrame / lpHdisp;
        fr = feCount - 1;                       // first displayed frame is 0
        expPix.red   = x[cRedW-1:0];
        expPix.green = y[cGreenW-1:0];
        expPix.blue  = fr[cBlueW-1:0];
        checkPix("oRgb", oRgb, expPix, ok);
        if (!ok)
            pixErrs++;
        pixSeen++;
    endtask

    // black outside the display area
    task automatic checkBlank();
        bit ok;
        checkPix("oRgb", oRgb, lpBlank, ok);
        if (!ok)
            pixErrs++;
    endtask

    // ------------------------------
    // monitor, mid-cycle sampling
    // ------------------------------
    always @(negedge iCLK)
    begin
        if (!iRST)
        begin
            if (feCount == 0)
                checkQuiet();
            if (oUnderflow)
                underflowSeen = 1'b1;
            // hsync period and width
            if (hsPer >= 0)
                hsPer++;
            if (oHsync)
                hsW++;
            if (oHsync && !prevHs)
            begin
                if (hsPer > 0)
                    trackRange(hsPerMin, hsPerMax, hsPer);
                hsPer = 0;
            end
            if (!oHsync && prevHs)
            begin
                trackRange(hsWMin, hsWMax, hsW);
                hsW = 0;
            end
            // vsync width
            if (oVsync)
                vsW++;
            if (!oVsync && prevVs)
            begin
                trackRange(vsWMin, vsWMax, vsW);
                vsW = 0;
            end
            // display enable and pixels
            if (oVde)
            begin
                checkPixelAt();
                vdeFrame++;
                vdeRun++;
            end
            else if (feCount > 0)
            begin
                checkBlank();                   // blanking
            end
            if (!oVde && prevVde)
            begin
                trackRange(runMin, runMax, vdeRun);
                vdeRun = 0;
                vdeLines++;
            end
            // frame end
            if (fePer >= 0)
                fePer++;
            if (oFe)
                feW++;
            if (oFe && !prevFe)
            begin
                if (fePer > 0)
                    trackRange(fePerMin, fePerMax, fePer);
                fePer = 0;
                if (feCount == 0)
                    firstVde = vdeFrame;
                else
                begin
                    trackRange(frMin, frMax, vdeFrame);
                    trackRange(linesMin, linesMax, vdeLines);
                end
                vdeFrame = 0;
                vdeLines = 0;
                feCount++;
            end
            if (!oFe && prevFe)
            begin
                if (feW > feWMax)
                    feWMax = feW;
                feW = 0;
            end
            prevHs  = oHsync;
            prevVs  = oVsync;
            prevVde = oVde;
            prevFe  = oFe;
        end
    end

    // loop until the monitor has seen oFe number target
    task automatic waitFrameEnd(input int target, output bit late);
        int cycles;
        cycles = 0;
        while (feCount < target && cycles < lpFeWait)
        begin
            @(posedge iCLK);
            cycles++;
        end
        late = (feCount < target);
        if (late)
            $display("timeout: oFe pulse %0d did not come within %0d clocks", target, lpFeWait);
    endtask

    // ------------------------------
    // main sequence
    // ------------------------------
    initial
    begin
        bit timedOut;
        bit ok;
        timedOut = 1'b0;
        iRST = 1'b1;
        repeat (2) @(posedge iCLK);
        #2 iRST = 1'b0;
        // blank first frame, then the displayed ones
        for (int f = 1; f <= lpFrames + 1; f++)
        begin
            if (!timedOut)
                waitFrameEnd(f, timedOut);
        end
        logResult("oFe arrives within timeout", !timedOut);
        if (!timedOut)
        begin
            addRow("oHsync period min", hsPerMin, lpHtotal);
            addRow("oHsync period max", hsPerMax, lpHtotal);
            addRow("oHsync width min", hsWMin, lpHsync);
            addRow("oHsync width max", hsWMax, lpHsync);
            addRow("oVsync width min", vsWMin, lpVsync * lpHtotal);
            addRow("oVsync width max", vsWMax, lpVsync * lpHtotal);
            addRow("oFe period min", fePerMin, lpHtotal * lpVtotal);
            addRow("oFe period max", fePerMax, lpHtotal * lpVtotal);
            addRow("oFe width max", feWMax, 1);
            addRow("oVde in first frame", firstVde, 0);
            addRow("oVde per frame min", frMin, lpHdisp * lpVdisp);
            addRow("oVde per frame max", frMax, lpHdisp * lpVdisp);
            addRow("oVde lines per frame min", linesMin, lpVdisp);
            addRow("oVde lines per frame max", linesMax, lpVdisp);
            addRow("oVde per line min", runMin, lpHdisp);
            addRow("oVde per line max", runMax, lpHdisp);
            for (int i = 0; i < rowName.size(); i++)
            begin
                checkCount(rowName[i], rowGot[i], rowExp[i], ok);
                logResult(rowName[i], ok);
            end
            logResult("outputs quiet until first oFe", quietErrs == 0);
            checkCount("oRgb pixels shown", pixSeen, lpFrames * lpHdisp * lpVdisp, ok);
            logResult("oRgb pattern and blanking", ok && pixErrs == 0);
            checkCount("oUnderflow", int'(underflowSeen), 0, ok);
            logResult("oUnderflow stays low", ok);
        end
        $display("tests passed: %0d, failed: %0d", passCount, failCount);
        if (failCount == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

//--- hw/videoTop.sv
/*
 * raster video source
 * timing generator, pattern source, pixel FIFO and output
 * stage on one clock; RGB565 out aligned to display enable
 */
module videoTop import videoPkg::*;
#(
    parameter int pHdisplay  = 640,
    parameter int pHback     = 48,
    parameter int pHfront    = 16,
    parameter int pHsync     = 96,
    parameter int pVdisplay  = 480,
    parameter int pVtop      = 31,
    parameter int pVbottom   = 11,
    parameter int pVsync     = 2,
    parameter int pFifoDepth = 16   // power of two
)(
    input  logic  iCLK,
    input  logic  iRST,
    output logic  oHsync,
    output logic  oVsync,
    output logic  oVde,
    output logic  oFe,
    output logic  oUnderflow,
    output pixelT oRgb
);

    pixStreamIf srcIf ();           // pattern source to FIFO

    logic  fvde, pop, empty;
    pixelT rdData;

    // ------------------------------
    // timing
    // ------------------------------
    hvsyncGen #(
        .pHdisplay(pHdisplay), .pHback(pHback), .pHfront(pHfront), .pHsync(pHsync),
        .pVdisplay(pVdisplay), .pVtop(pVtop), .pVbottom(pVbottom), .pVsync(pVsync)
    ) uTiming (
        .iCLK(iCLK), .iRST(iRST), .hsync(oHsync), .vsync(oVsync),
        .vde(oVde), .fvde(fvde), .fe(oFe)
    );

    // ------------------------------
    // pixel path
    // ------------------------------
    patternGen #(.pHdisplay(pHdisplay), .pVdisplay(pVdisplay)) uPattern (
        .iCLK(iCLK), .iRST(iRST), .src(srcIf.source)
    );

    pixelFifo #(.pFifoDepth(pFifoDepth)) uFifo (
        .iCLK(iCLK), .iRST(iRST), .snk(srcIf.sink),
        .pop(pop), .rdData(rdData), .empty(empty)
    );

    videoOut uOut (
        .iCLK(iCLK), .iRST(iRST), .fvde(fvde), .rdData(rdData), .empty(empty),
        .pop(pop), .rgb(oRgb), .underflow(oUnderflow)
    );

endmodule

//--- hw/videoOut.sv
/*
 * output stage
 * pops the FIFO on the fast enable and registers the colour
 * two clocks later, in step with vde; an empty pop gives the
 * underflow colour and sets a sticky flag
 */
module videoOut import videoPkg::*;
(
    input  logic  iCLK,
    input  logic  iRST,
    input  logic  fvde,         // 2 clocks ahead of vde
    input  pixelT rdData,       // valid 1 clock after pop
    input  logic  empty,
    output logic  pop,
    output pixelT rgb,
    output logic  underflow
);

    logic       rPopQ;          // pop seen last clock
    logic [1:0] rMissPipe;      // pop found FIFO empty, 2 stages

    assign pop = fvde;          // one pop per display pixel

    // ------------------------------
    // pixel register
    // ------------------------------
    always_ff @(posedge iCLK)
    begin
        if (iRST)
        begin
            rPopQ     <= 1'b0;
            rMissPipe <= '0;
            rgb       <= '0;
        end
        else
        begin
            rPopQ     <= pop;
            rMissPipe <= {rMissPipe[0], pop & empty};
            if (rPopQ)
                rgb <= rMissPipe[0] ? cUnderflowPix : rdData;
            else
                rgb <= '0;              // blank outside display area
        end
    end

    // sticky until reset
    always_ff @(posedge iCLK)
    begin
        if (iRST)
            underflow <= 1'b0;
        else if (rMissPipe[1])
            underflow <= 1'b1;
    end

endmodule

//--- hw/pixelFifo.sv
/*
 * pixel FIFO
 * single-clock circular buffer between the pattern source
 * and the output stage; read data is registered, so a word
 * appears one clock after its pop
 */
module pixelFifo import videoPkg::*;
#(
    parameter int pFifoDepth = 16   // power of two
)(
    input  logic  iCLK,
    input  logic  iRST,
    pixStreamIf.sink snk,
    input  logic  pop,
    output pixelT rdData,
    output logic  empty
);

    localparam int lpAw = $clog2(pFifoDepth);

    pixelT           mem [pFifoDepth];
    logic [lpAw:0]   rWrPtr, rRdPtr;    // extra msb tells full from empty
    logic            qFull, qPush, qPop;

    // ------------------------------
    // status
    // ------------------------------
    assign qFull = (rWrPtr[lpAw] != rRdPtr[lpAw]) &&
                   (rWrPtr[lpAw-1:0] == rRdPtr[lpAw-1:0]);
    assign empty = (rWrPtr == rRdPtr);

    assign snk.ready = ~qFull;
    assign qPush     = snk.valid & ~qFull;
    assign qPop      = pop & ~empty;        // pop on empty ignored

    // ------------------------------
    // storage
    // ------------------------------
    always_ff @(posedge iCLK)
    begin
        if (qPush)
            mem[rWrPtr[lpAw-1:0]] <= snk.pix;   // flags dropped here
    end

    // registered read port
    always_ff @(posedge iCLK)
    begin
        if (qPop)
            rdData <= mem[rRdPtr[lpAw-1:0]];
    end

    // ------------------------------
    // pointers
    // ------------------------------
    always_ff @(posedge iCLK)
    begin
        if (iRST)
        begin
            rWrPtr <= '0;
            rRdPtr <= '0;
        end
        else
        begin
            if (qPush)
                rWrPtr <= rWrPtr + 1'b1;
            if (qPop)
                rRdPtr <= rRdPtr + 1'b1;
        end
    end

endmodule

//--- hw/patternGen.sv
/*
 * pattern source
 * walks the display area in raster order and pushes one
 * RGB565 word per pixel: red from x, green from y, blue from
 * a frame count; position stalls while the FIFO is full
 */
module patternGen import videoPkg::*;
#(
    parameter int pHdisplay = 640,  // pixels per line
    parameter int pVdisplay = 480   // lines per frame
)(
    input  logic iCLK,
    input  logic iRST,
    pixStreamIf.source src
);

    // counters at least as wide as the colour fields they feed
    localparam int lpXw = ($clog2(pHdisplay) > cRedW) ? $clog2(pHdisplay) : cRedW;
    localparam int lpYw = ($clog2(pVdisplay) > cGreenW) ? $clog2(pVdisplay) : cGreenW;

    logic [lpXw-1:0]   rX;
    logic [lpYw-1:0]   rY;
    logic [cBlueW-1:0] rFrame;      // wraps at 32
    logic              rValid;
    logic              qFire, qLastX, qLastY;

    assign qFire  = rValid & src.ready;         // word taken this edge
    assign qLastX = (rX == lpXw'(pHdisplay - 1));
    assign qLastY = (rY == lpYw'(pVdisplay - 1));

    // one idle cycle out of reset, then always offering
    always_ff @(posedge iCLK)
    begin
        if (iRST)
            rValid <= 1'b0;
        else
            rValid <= 1'b1;
    end

    // ------------------------------
    // raster position
    // ------------------------------
    always_ff @(posedge iCLK)
    begin
        if (iRST)
        begin
            rX     <= '0;
            rY     <= '0;
            rFrame <= '0;
        end
        else if (qFire)
        begin
            if (qLastX)
            begin
                rX <= '0;
                if (qLastY)
                begin
                    rY     <= '0;
                    rFrame <= rFrame + 1'b1;    // next frame
                end
                else
                begin
                    rY <= rY + 1'b1;
                end
            end
            else
            begin
                rX <= rX + 1'b1;
            end
        end
    end

    // held stable by the stalled position when not ready
    assign src.valid = rValid;
    assign src.pix   = '{red: rX[cRedW-1:0], green: rY[cGreenW-1:0], blue: rFrame};
    assign src.sof   = (rX == '0) && (rY == '0);
    assign src.eol   = qLastX;

endmodule

//--- hw/hvsyncGen.sv
/*
 * raster timing generator
 * horizontal/vertical counters wrapping at the frame totals,
 * hsync/vsync through a two-register decode, display enable,
 * one-clock frame end, and a fast enable two clocks ahead of
 * vde for the FIFO read latency
 * sync and enables stay quiet until the first frame end
 */
module hvsyncGen
#(
    parameter int pHdisplay = 640,  // visible pixels per line
    parameter int pHback    = 48,   // left border
    parameter int pHfront   = 16,   // right border
    parameter int pHsync    = 96,   // hsync width in clocks
    parameter int pVdisplay = 480,  // visible lines
    parameter int pVtop     = 31,   // top border lines
    parameter int pVbottom  = 11,   // bottom border lines
    parameter int pVsync    = 2     // vsync width in lines
)(
    input  logic iCLK,
    input  logic iRST,
    output logic hsync,
    output logic vsync,
    output logic vde,               // display area
    output logic fvde,              // vde, 2 clocks early
    output logic fe                 // frame end, one clock
);

    // position of the msb set, at least 1
    function automatic int fBitWidth(input int unsigned val);
        int w;
        w = 1;
        for (int i = 0; i < 32; i++)
        begin
            if (val[i])
            begin
                w = i + 1;
            end
        end
        return w;
    endfunction

    localparam int lpHtotal     = pHdisplay + pHback + pHfront + pHsync;
    localparam int lpHmax       = lpHtotal - 1;
    localparam int lpHsyncStart = pHdisplay + pHfront;
    localparam int lpHsyncEnd   = lpHsyncStart + pHsync - 1;
    localparam int lpVtotal     = pVdisplay + pVtop + pVbottom + pVsync;
    localparam int lpVmax       = lpVtotal - 1;
    localparam int lpVsyncStart = pVdisplay + pVbottom;
    localparam int lpVsyncEnd   = lpVsyncStart + pVsync - 1;
    localparam int lpLead       = 2;                    // fast counter head start
    localparam int lpHw         = fBitWidth(lpHtotal);
    localparam int lpVw         = fBitWidth(lpVtotal);

    logic [lpHw-1:0] rHpos, rFhPos;
    logic [lpVw-1:0] rVpos, rFvPos;
    logic [1:0]      rHsyncPipe, rVsyncPipe;    // two-stage sync decode
    logic            rVde, rFvde, rFe;
    logic            rArmed;                    // set by first frame end
    logic            qHmatch, qVmatch, qFhMatch, qFvMatch;
    logic            qHrange, qVrange, qVde, qFvde, qFe;

    // ------------------------------
    // raster counters
    // ------------------------------
    always_ff @(posedge iCLK)
    begin
        if (iRST)
        begin
            rHpos <= '0;
            rVpos <= '0;
        end
        else if (qHmatch)
        begin
            rHpos <= '0;                            // end of line
            rVpos <= qVmatch ? '0 : rVpos + 1'b1;
        end
        else
        begin
            rHpos <= rHpos + 1'b1;
        end
    end

    // fast pair, always lpLead counts ahead
    always_ff @(posedge iCLK)
    begin
        if (iRST)
        begin
            rFhPos <= lpHw'(lpLead);
            rFvPos <= '0;
        end
        else if (qFhMatch)
        begin
            rFhPos <= '0;
            rFvPos <= qFvMatch ? '0 : rFvPos + 1'b1;
        end
        else
        begin
            rFhPos <= rFhPos + 1'b1;
        end
    end

    // ------------------------------
    // decode
    // ------------------------------
    always_comb
    begin
        qHmatch  = (rHpos == lpHw'(lpHmax));
        qVmatch  = (rVpos == lpVw'(lpVmax));
        qFhMatch = (rFhPos == lpHw'(lpHmax));
        qFvMatch = (rFvPos == lpVw'(lpVmax));
        qHrange  = (rHpos >= lpHw'(lpHsyncStart)) && (rHpos <= lpHw'(lpHsyncEnd));
        qVrange  = (rVpos >= lpVw'(lpVsyncStart)) && (rVpos <= lpVw'(lpVsyncEnd));
        qVde     = (rHpos < lpHw'(pHdisplay)) && (rVpos < lpVw'(pVdisplay));
        qFvde    = (rFhPos < lpHw'(pHdisplay)) && (rFvPos < lpVw'(pVdisplay));
        qFe      = (rHpos == lpHw'(pHdisplay)) && (rVpos == lpVw'(pVdisplay));
    end

    // ------------------------------
    // output registers
    // ------------------------------
    always_ff @(posedge iCLK)
    begin
        if (iRST)
        begin
            rHsyncPipe <= '0;
            rVsyncPipe <= '0;
            rVde       <= 1'b0;
            rFvde      <= 1'b0;
            rFe        <= 1'b0;
            rArmed     <= 1'b0;
        end
        else
        begin
            rHsyncPipe <= {rHsyncPipe[0], qHrange & rArmed};
            rVsyncPipe <= {rVsyncPipe[0], qVrange & rArmed};
            rVde       <= qVde & rArmed;        // first frame is blank
            rFvde      <= qFvde & rArmed;
            rFe        <= qFe;
            rArmed     <= rArmed | qFe;         // sticky after first fe
        end
    end

    assign hsync = rHsyncPipe[1];
    assign vsync = rVsyncPipe[1];
    assign vde   = rVde;
    assign fvde  = rFvde;
    assign fe    = rFe;

endmodule

//--- hw/pixStreamIf.sv
/*
 * pixel stream
 * valid/ready transport of RGB565 words from the pattern
 * source into the pixel FIFO, with frame/line markers
 */
interface pixStreamIf import videoPkg::*; ();

    pixelT pix;     // colour word
    logic  valid;   // source has a word
    logic  ready;   // sink can take it
    logic  sof;     // first pixel of a frame
    logic  eol;     // last pixel of a line

    // producer side
    modport source (output pix, output valid, output sof, output eol, input ready);

    // consumer side
    modport sink (input pix, input valid, input sof, input eol, output ready);

endinterface

//--- hw/videoPkg.sv
/*
 * video package
 * RGB565 pixel word and the colour constants shared by the
 * pattern source, the pixel FIFO and the output stage
 */
package videoPkg;

    // ------------------------------
    // colour field widths
    // ------------------------------
    localparam int cRedW   = 5;     // red, msb side of the word
    localparam int cGreenW = 6;     // green gets the extra bit
    localparam int cBlueW  = 5;     // blue, lsb side

    // ------------------------------
    // pixel word
    // ------------------------------
    // rgb565, red in [15:11], green in [10:5], blue in [4:0]
    typedef struct packed {
        logic [cRedW-1:0]   red;
        logic [cGreenW-1:0] green;
        logic [cBlueW-1:0]  blue;
    } pixelT;

    // ------------------------------
    // special colours
    // ------------------------------
    // driven out when a pop finds the FIFO empty
    localparam pixelT cUnderflowPix = '0;   // black

endpackage
